// File: rtl/astar_pkg.sv
package astar_pkg;

   // Slot table and queue thread count
   localparam int SLOTS = 16;
   localparam int SLOT_W = 4;

   // Bytes per vertex coordinate word
   localparam int COORD_STRIDE = 8;

   // Pending FIFO fill at which dequeue stops
   localparam int FIFO_ALMOST_FULL = 6;

   typedef logic [SLOT_W-1:0] slot_id_t;
   typedef logic [31:0] vid_t;
   typedef logic [31:0] score_t;
   typedef logic [31:0] coord_t;
   typedef logic [31:0] addr_t;
   typedef logic [7:0] cq_slot_t;

   typedef enum logic [2:0] {
      SLOT_FREE,
      SLOT_FETCH,
      SLOT_DIST,
      SLOT_ENQ,
      SLOT_FINISH
   } slot_state_t;

endpackage

// File: rtl/slot_fifo.sv
`timescale 1ns/1ps

module slot_fifo #(
   parameter int WIDTH = 4
) (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic                       wr_en,
   input  logic [WIDTH-1:0]           wr_data,
   input  logic                       rd_en,
   output logic [WIDTH-1:0]           rd_data,
   output logic                       empty,
   output logic [astar_pkg::SLOT_W:0] fill
);
   import astar_pkg::*;

   logic [WIDTH-1:0] mem [SLOTS];
   slot_id_t wr_ptr;
   slot_id_t rd_ptr;

   // Head word falls through to the output
   assign rd_data = mem[rd_ptr];
   assign empty = (fill == '0);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10: fill <= fill + 1'b1;
            2'b01: fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

endmodule

// File: rtl/task_dequeue.sv
`timescale 1ns/1ps

module task_dequeue (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          start,
   input  astar_pkg::addr_t              coord_base,
   output logic [astar_pkg::SLOTS-1:0]   task_arvalid,
   input  logic [astar_pkg::SLOTS-1:0]   task_rvalid,
   input  astar_pkg::vid_t               task_vid,
   input  astar_pkg::score_t             task_fscore,
   input  astar_pkg::score_t             task_gscore,
   input  astar_pkg::vid_t               task_parent,
   input  astar_pkg::cq_slot_t           task_cq_slot,
   output logic                          mem_arvalid,
   output astar_pkg::addr_t              mem_araddr,
   output astar_pkg::slot_id_t           mem_arid,
   input  logic                          mem_arready,
   input  logic                          mem_rvalid,
   input  astar_pkg::slot_id_t           mem_rid,
   output astar_pkg::score_t             resp_fscore,
   input  astar_pkg::slot_id_t           lookup_slot,
   output astar_pkg::vid_t               lookup_vid,
   output astar_pkg::score_t             lookup_fscore,
   output astar_pkg::score_t             lookup_gscore,
   output astar_pkg::vid_t               lookup_parent,
   output astar_pkg::cq_slot_t           lookup_cq_slot,
   input  logic                          enq_done,
   input  astar_pkg::slot_id_t           done_slot,
   input  logic                          fin_done,
   input  astar_pkg::slot_id_t           fin_slot
);
   import astar_pkg::*;

   slot_state_t state [SLOTS];
   vid_t slot_vid [SLOTS];
   score_t slot_fscore [SLOTS];
   score_t slot_gscore [SLOTS];
   vid_t slot_parent [SLOTS];
   cq_slot_t slot_cq [SLOTS];

   logic [SLOTS-1:0] deq_hit;
   logic deq_valid;
   slot_id_t deq_slot;
   logic pend_empty;
   logic [SLOT_W:0] pend_fill;
   slot_id_t pend_head;

   // Response delayed by the distance pipeline depth
   logic rsp_v1;
   logic rsp_v2;
   slot_id_t rsp_id1;
   slot_id_t rsp_id2;

   assign deq_hit = task_arvalid & task_rvalid;
   assign deq_valid = |deq_hit;

   // Lowest ready slot wins
   always_comb begin
      deq_slot = '0;
      for (int i = SLOTS - 1; i >= 0; i--) begin
         if (deq_hit[i]) begin
            deq_slot = slot_id_t'(i);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (deq_valid) begin
         slot_vid[deq_slot] <= task_vid;
         slot_fscore[deq_slot] <= task_fscore;
         slot_gscore[deq_slot] <= task_gscore;
         slot_parent[deq_slot] <= task_parent;
         slot_cq[deq_slot] <= task_cq_slot;
      end
   end

   slot_fifo #(
      .WIDTH(SLOT_W)
   ) i_pending (
      .clk(clk),
      .rstn(rstn),
      .wr_en(deq_valid),
      .wr_data(deq_slot),
      .rd_en(mem_arvalid & mem_arready),
      .rd_data(pend_head),
      .empty(pend_empty),
      .fill(pend_fill)
   );

   // One coordinate read per pending head
   assign mem_arvalid = !pend_empty;
   assign mem_arid = pend_head;
   assign mem_araddr = coord_base + addr_t'(slot_vid[pend_head]) * addr_t'(COORD_STRIDE);

   assign resp_fscore = slot_fscore[mem_rid];

   assign lookup_vid = slot_vid[lookup_slot];
   assign lookup_fscore = slot_fscore[lookup_slot];
   assign lookup_gscore = slot_gscore[lookup_slot];
   assign lookup_parent = slot_parent[lookup_slot];
   assign lookup_cq_slot = slot_cq[lookup_slot];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rsp_v1 <= 1'b0;
         rsp_v2 <= 1'b0;
      end else begin
         rsp_v1 <= mem_rvalid;
         rsp_v2 <= rsp_v1;
      end
      rsp_id1 <= mem_rid;
      rsp_id2 <= rsp_id1;
   end

   for (genvar i = 0; i < SLOTS; i++) begin : g_slot
      assign task_arvalid[i] = (state[i] == SLOT_FREE) && start
         && (pend_fill < (SLOT_W + 1)'(FIFO_ALMOST_FULL));

      always_ff @(posedge clk) begin
         if (!rstn) begin
            state[i] <= SLOT_FREE;
         end else begin
            case (state[i])
               SLOT_FREE: begin
                  if (deq_valid && deq_slot == slot_id_t'(i)) begin
                     state[i] <= SLOT_FETCH;
                  end
               end
               SLOT_FETCH: begin
                  if (mem_rvalid && mem_rid == slot_id_t'(i)) begin
                     state[i] <= SLOT_DIST;
                  end
               end
               SLOT_DIST: begin
                  // Sum is now in the completed FIFO
                  if (rsp_v2 && rsp_id2 == slot_id_t'(i)) begin
                     state[i] <= SLOT_ENQ;
                  end
               end
               SLOT_ENQ: begin
                  if (enq_done && done_slot == slot_id_t'(i)) begin
                     state[i] <= SLOT_FINISH;
                  end
               end
               SLOT_FINISH: begin
                  if (fin_done && fin_slot == slot_id_t'(i)) begin
                     state[i] <= SLOT_FREE;
                  end
               end
               default: state[i] <= SLOT_FREE;
            endcase
         end
      end
   end

endmodule

// File: rtl/dist_pipe.sv
`timescale 1ns/1ps

module dist_pipe (
   input  logic                clk,
   input  logic                rstn,
   input  logic                in_valid,
   input  astar_pkg::slot_id_t in_slot,
   input  astar_pkg::score_t   in_fscore,
   input  astar_pkg::coord_t   src_lat,
   input  astar_pkg::coord_t   src_lon,
   input  astar_pkg::coord_t   tgt_lat,
   input  astar_pkg::coord_t   tgt_lon,
   output logic                out_valid,
   output astar_pkg::slot_id_t out_slot,
   output astar_pkg::score_t   out_sum
);
   import astar_pkg::*;

   logic s1_valid;
   slot_id_t s1_slot;
   score_t s1_fscore;
   coord_t s1_dlat;
   coord_t s1_dlon;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         s1_valid <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         s1_valid <= in_valid;
         out_valid <= s1_valid;
      end
   end

   // Stage one forms the absolute coordinate differences
   always_ff @(posedge clk) begin
      s1_slot <= in_slot;
      s1_fscore <= in_fscore;
      s1_dlat <= (src_lat > tgt_lat) ? src_lat - tgt_lat : tgt_lat - src_lat;
      s1_dlon <= (src_lon > tgt_lon) ? src_lon - tgt_lon : tgt_lon - src_lon;
   end

   // Stage two adds the Manhattan distance to the f-score
   always_ff @(posedge clk) begin
      out_slot <= s1_slot;
      out_sum <= s1_fscore + s1_dlat + s1_dlon;
   end

endmodule

// File: rtl/child_enqueue.sv
`timescale 1ns/1ps

module child_enqueue (
   input  logic                        clk,
   input  logic                        rstn,
   input  logic                        cmp_empty,
   input  astar_pkg::slot_id_t         cmp_slot,
   input  astar_pkg::score_t           cmp_sum,
   output logic                        cmp_pop,
   output astar_pkg::slot_id_t         lookup_slot,
   input  astar_pkg::vid_t             lookup_vid,
   input  astar_pkg::score_t           lookup_fscore,
   input  astar_pkg::score_t           lookup_gscore,
   input  astar_pkg::vid_t             lookup_parent,
   input  astar_pkg::cq_slot_t         lookup_cq_slot,
   output logic                        task_wvalid,
   input  logic                        task_wready,
   output astar_pkg::score_t           task_wts,
   output astar_pkg::vid_t             task_wvid,
   output astar_pkg::vid_t             task_wparent,
   output astar_pkg::score_t           task_wfscore,
   output logic [astar_pkg::SLOTS-1:0] finish_valid,
   input  logic [astar_pkg::SLOTS-1:0] finish_ready,
   output astar_pkg::cq_slot_t         finish_cq_slot,
   output logic                        enq_done,
   output astar_pkg::slot_id_t         done_slot,
   output logic                        fin_done,
   output astar_pkg::slot_id_t         fin_slot
);

   logic fin_pend;

   // The lookup port serves a pending finish before the FIFO head
   assign lookup_slot = fin_pend ? fin_slot : cmp_slot;

   // No child while a finish waits
   assign task_wvalid = !cmp_empty && !fin_pend;
   assign task_wts = (lookup_gscore > cmp_sum) ? lookup_gscore : cmp_sum;
   assign task_wvid = lookup_vid;
   assign task_wparent = lookup_parent;
   assign task_wfscore = lookup_fscore;

   assign cmp_pop = task_wvalid && task_wready;
   assign enq_done = cmp_pop;
   assign done_slot = cmp_slot;

   always_comb begin
      finish_valid = '0;
      finish_valid[fin_slot] = fin_pend;
   end

   assign finish_cq_slot = lookup_cq_slot;
   assign fin_done = fin_pend && finish_ready[fin_slot];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         fin_pend <= 1'b0;
      end else if (fin_done) begin
         fin_pend <= 1'b0;
      end else if (cmp_pop) begin
         fin_pend <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (cmp_pop) begin
         fin_slot <= cmp_slot;
      end
   end

endmodule

// File: rtl/astar_core.sv
`timescale 1ns/1ps

module astar_core (
   input  logic                        clk,
   input  logic                        rstn,
   input  logic                        start,
   input  astar_pkg::addr_t            coord_base,
   input  astar_pkg::coord_t           tgt_lat,
   input  astar_pkg::coord_t           tgt_lon,
   output logic [astar_pkg::SLOTS-1:0] task_arvalid,
   input  logic [astar_pkg::SLOTS-1:0] task_rvalid,
   input  astar_pkg::vid_t             task_vid,
   input  astar_pkg::score_t           task_fscore,
   input  astar_pkg::score_t           task_gscore,
   input  astar_pkg::vid_t             task_parent,
   input  astar_pkg::cq_slot_t         task_cq_slot,
   output logic                        mem_arvalid,
   output astar_pkg::addr_t            mem_araddr,
   output astar_pkg::slot_id_t         mem_arid,
   input  logic                        mem_arready,
   input  logic                        mem_rvalid,
   input  astar_pkg::slot_id_t         mem_rid,
   input  astar_pkg::coord_t           mem_rlat,
   input  astar_pkg::coord_t           mem_rlon,
   output logic                        task_wvalid,
   input  logic                        task_wready,
   output astar_pkg::score_t           task_wts,
   output astar_pkg::vid_t             task_wvid,
   output astar_pkg::vid_t             task_wparent,
   output astar_pkg::score_t           task_wfscore,
   output logic [astar_pkg::SLOTS-1:0] finish_valid,
   input  logic [astar_pkg::SLOTS-1:0] finish_ready,
   output astar_pkg::cq_slot_t         finish_cq_slot
);
   import astar_pkg::*;

   score_t resp_fscore;
   slot_id_t lookup_slot;
   vid_t lookup_vid;
   score_t lookup_fscore;
   score_t lookup_gscore;
   vid_t lookup_parent;
   cq_slot_t lookup_cq_slot;
   logic enq_done;
   slot_id_t done_slot;
   logic fin_done;
   slot_id_t fin_slot;

   logic pipe_valid;
   slot_id_t pipe_slot;
   score_t pipe_sum;

   logic [SLOT_W+31:0] cmp_data;
   logic cmp_empty;
   logic cmp_pop;

   task_dequeue i_task_dequeue (
      .clk(clk),
      .rstn(rstn),
      .start(start),
      .coord_base(coord_base),
      .task_arvalid(task_arvalid),
      .task_rvalid(task_rvalid),
      .task_vid(task_vid),
      .task_fscore(task_fscore),
      .task_gscore(task_gscore),
      .task_parent(task_parent),
      .task_cq_slot(task_cq_slot),
      .mem_arvalid(mem_arvalid),
      .mem_araddr(mem_araddr),
      .mem_arid(mem_arid),
      .mem_arready(mem_arready),
      .mem_rvalid(mem_rvalid),
      .mem_rid(mem_rid),
      .resp_fscore(resp_fscore),
      .lookup_slot(lookup_slot),
      .lookup_vid(lookup_vid),
      .lookup_fscore(lookup_fscore),
      .lookup_gscore(lookup_gscore),
      .lookup_parent(lookup_parent),
      .lookup_cq_slot(lookup_cq_slot),
      .enq_done(enq_done),
      .done_slot(done_slot),
      .fin_done(fin_done),
      .fin_slot(fin_slot)
   );

   // Responses are always taken at one per cycle
   dist_pipe i_dist_pipe (
      .clk(clk),
      .rstn(rstn),
      .in_valid(mem_rvalid),
      .in_slot(mem_rid),
      .in_fscore(resp_fscore),
      .src_lat(mem_rlat),
      .src_lon(mem_rlon),
      .tgt_lat(tgt_lat),
      .tgt_lon(tgt_lon),
      .out_valid(pipe_valid),
      .out_slot(pipe_slot),
      .out_sum(pipe_sum)
   );

   slot_fifo #(
      .WIDTH(SLOT_W + 32)
   ) i_completed (
      .clk(clk),
      .rstn(rstn),
      .wr_en(pipe_valid),
      .wr_data({pipe_slot, pipe_sum}),
      .rd_en(cmp_pop),
      .rd_data(cmp_data),
      .empty(cmp_empty),
      .fill()
   );

   child_enqueue i_child_enqueue (
      .clk(clk),
      .rstn(rstn),
      .cmp_empty(cmp_empty),
      .cmp_slot(cmp_data[SLOT_W+31:32]),
      .cmp_sum(cmp_data[31:0]),
      .cmp_pop(cmp_pop),
      .lookup_slot(lookup_slot),
      .lookup_vid(lookup_vid),
      .lookup_fscore(lookup_fscore),
      .lookup_gscore(lookup_gscore),
      .lookup_parent(lookup_parent),
      .lookup_cq_slot(lookup_cq_slot),
      .task_wvalid(task_wvalid),
      .task_wready(task_wready),
      .task_wts(task_wts),
      .task_wvid(task_wvid),
      .task_wparent(task_wparent),
      .task_wfscore(task_wfscore),
      .finish_valid(finish_valid),
      .finish_ready(finish_ready),
      .finish_cq_slot(finish_cq_slot),
      .enq_done(enq_done),
      .done_slot(done_slot),
      .fin_done(fin_done),
      .fin_slot(fin_slot)
   );

endmodule

// File: test/astar_core_chk.sv
`timescale 1ns/1ps

module astar_core_chk (
   input logic                        clk,
   input logic                        rstn,
   input logic                        start,
   input logic [astar_pkg::SLOTS-1:0] task_arvalid,
   input logic                        mem_arvalid,
   input logic                        mem_arready,
   input astar_pkg::addr_t            mem_araddr,
   input logic                        task_wvalid,
   input logic                        task_wready,
   input astar_pkg::score_t           task_wts,
   input astar_pkg::vid_t             task_wvid,
   input astar_pkg::vid_t             task_wparent,
   input astar_pkg::score_t           task_wfscore,
   input logic [astar_pkg::SLOTS-1:0] finish_valid
);
   import astar_pkg::*;

   int fails = 0;

   // Child offer holds until the queue takes it
   a_child_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_wvalid && !task_wready |=> task_wvalid && $stable(task_wts)
         && $stable(task_wvid) && $stable(task_wparent) && $stable(task_wfscore))
   else begin
      fails++;
      $error("child offer changed while task_wready was low");
   end

   a_finish_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(finish_valid))
   else begin
      fails++;
      $error("finish_valid has more than one bit set");
   end

   a_read_hold: assert property (@(posedge clk) disable iff (!rstn)
      mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
   else begin
      fails++;
      $error("read request dropped or changed before mem_arready");
   end

   a_no_start: assert property (@(posedge clk) disable iff (!rstn)
      !start |-> task_arvalid == '0)
   else begin
      fails++;
      $error("task_arvalid raised while start is low");
   end

endmodule

bind astar_core astar_core_chk i_astar_core_chk (
   .clk(clk),
   .rstn(rstn),
   .start(start),
   .task_arvalid(task_arvalid),
   .mem_arvalid(mem_arvalid),
   .mem_arready(mem_arready),
   .mem_araddr(mem_araddr),
   .task_wvalid(task_wvalid),
   .task_wready(task_wready),
   .task_wts(task_wts),
   .task_wvid(task_wvid),
   .task_wparent(task_wparent),
   .task_wfscore(task_wfscore),
   .finish_valid(finish_valid)
);

// File: test/astar_core_tb.sv
`timescale 1ns/1ps

module astar_core_tb;
   import astar_pkg::*;

   localparam int NTASKS = 64;
   localparam int LIMIT = NTASKS * 40;
   localparam addr_t BASE = 32'h1000_0000;
   localparam coord_t TGT_LAT = 32'h0008_0000;
   localparam coord_t TGT_LON = 32'h0004_0000;

   logic clk = 1'b0;
   logic rstn;
   logic start;
   addr_t coord_base;
   coord_t tgt_lat;
   coord_t tgt_lon;
   logic [SLOTS-1:0] task_arvalid;
   logic [SLOTS-1:0] task_rvalid;
   vid_t task_vid;
   score_t task_fscore;
   score_t task_gscore;
   vid_t task_parent;
   cq_slot_t task_cq_slot;
   logic mem_arvalid;
   addr_t mem_araddr;
   slot_id_t mem_arid;
   logic mem_arready;
   logic mem_rvalid;
   slot_id_t mem_rid;
   coord_t mem_rlat;
   coord_t mem_rlon;
   logic task_wvalid;
   logic task_wready;
   score_t task_wts;
   vid_t task_wvid;
   vid_t task_wparent;
   score_t task_wfscore;
   logic [SLOTS-1:0] finish_valid;
   logic [SLOTS-1:0] finish_ready;
   cq_slot_t finish_cq_slot;

   integer seed = 32'h2701_3b82;
   int cycles = 0;
   int errors = 0;
   int end_errors = 0;
   int deq_count = 0;
   int child_count = 0;
   int fin_count = 0;
   int g_cases = 0;
   logic timed_out = 1'b0;

   // Model of the slot table and the outstanding reads
   logic [SLOTS-1:0] busy = '0;
   logic [SLOTS-1:0] req_pend = '0;
   vid_t t_vid [SLOTS];
   score_t t_f [SLOTS];
   score_t t_g [SLOTS];
   vid_t t_par [SLOTS];
   cq_slot_t t_cq [SLOTS];
   addr_t req_addr [SLOTS];
   int req_due [SLOTS];
   int pend_q [$];
   int resp_q [$];
   int fin_q [$];

   astar_core i_astar_core (.*);

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
   end

   // Coordinate words are fixed functions of the byte address
   function automatic coord_t lat_of(addr_t a);
      return ((a ^ (a >> 16)) * 32'h0000_9e37) & 32'h000f_ffff;
   endfunction

   function automatic coord_t lon_of(addr_t a);
      return ((a ^ (a >> 11)) * 32'h0000_7f4b) & 32'h000f_ffff;
   endfunction

   function automatic score_t expected_ts(score_t f, score_t g, addr_t a);
      score_t dlat;
      score_t dlon;
      score_t sum;
      dlat = (lat_of(a) > TGT_LAT) ? lat_of(a) - TGT_LAT : TGT_LAT - lat_of(a);
      dlon = (lon_of(a) > TGT_LON) ? lon_of(a) - TGT_LON : TGT_LON - lon_of(a);
      sum = f + dlat + dlon;
      return (g > sum) ? g : sum;
   endfunction

   task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
      assert (exp == act) else begin
         errors++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic drive_inputs();
      int pick;
      pick = -1;
      task_vid = $random(seed) & 32'h000f_ffff;
      task_fscore = $random(seed) & 32'h0000_ffff;
      task_gscore = $random(seed) & 32'h003f_ffff;
      task_parent = $random(seed);
      task_cq_slot = cq_slot_t'($random(seed));
      task_rvalid = (deq_count < NTASKS) ? (SLOTS'($random(seed)) & ~busy) : '0;
      mem_arready = ($random(seed) & 3) != 0;
      task_wready = ($random(seed) & 7) > 2;
      finish_ready = SLOTS'($random(seed));
      for (int s = 0; s < SLOTS; s++) begin
         if (pick < 0 && req_pend[s] && req_due[s] <= cycles) begin
            pick = s;
         end
      end
      mem_rvalid = (pick >= 0);
      mem_rid = slot_id_t'(pick);
      if (pick >= 0) begin
         mem_rlat = lat_of(req_addr[pick]);
         mem_rlon = lon_of(req_addr[pick]);
      end
   endtask

   // Observe handshakes at the falling edge, where every level is settled
   always @(negedge clk) begin
      int s;
      score_t exp_ts;
      if (rstn) begin
         if (!start) begin
            assert (task_arvalid == '0 && !mem_arvalid && !task_wvalid && finish_valid == '0)
            else begin
               errors++;
               $display("Outputs active while start is low");
            end
         end
         for (int i = 0; i < SLOTS; i++) begin
            assert (!(busy[i] && task_arvalid[i])) else begin
               errors++;
               $display("Slot %0d offered for dequeue before its finish", i);
            end
         end
         s = -1;
         for (int i = SLOTS - 1; i >= 0; i--) begin
            if (task_arvalid[i] && task_rvalid[i]) begin
               s = i;
            end
         end
         if (s >= 0) begin
            busy[s] = 1'b1;
            t_vid[s] = task_vid;
            t_f[s] = task_fscore;
            t_g[s] = task_gscore;
            t_par[s] = task_parent;
            t_cq[s] = task_cq_slot;
            pend_q.push_back(s);
            deq_count++;
         end
         if (mem_arvalid && mem_arready) begin
            assert (pend_q.size() != 0) else begin
               errors++;
               $display("Coordinate read issued with no dequeued task waiting");
            end
            if (pend_q.size() != 0) begin
               s = pend_q.pop_front();
               check_value("read_id", s, mem_arid);
               check_value("read_addr", BASE + t_vid[s] * COORD_STRIDE, mem_araddr);
               req_pend[mem_arid] = 1'b1;
               req_addr[mem_arid] = mem_araddr;
               req_due[mem_arid] = cycles + 1 + ($random(seed) & 3);
            end
         end
         if (mem_rvalid) begin
            req_pend[mem_rid] = 1'b0;
            resp_q.push_back(mem_rid);
         end
         // A finish must follow every child before the next one
         if (fin_q.size() != 0) begin
            s = fin_q[0];
            check_value("finish_valid", 1 << s, finish_valid);
            check_value("finish_cq_slot", t_cq[s], finish_cq_slot);
            if (finish_valid[s] && finish_ready[s]) begin
               busy[s] = 1'b0;
               void'(fin_q.pop_front());
               fin_count++;
            end
         end else begin
            check_value("finish_idle", 0, finish_valid);
         end
         if (task_wvalid && task_wready) begin
            assert (resp_q.size() != 0) else begin
               errors++;
               $display("Child enqueued with no memory response behind it");
            end
            if (resp_q.size() != 0) begin
               s = resp_q.pop_front();
               exp_ts = expected_ts(t_f[s], t_g[s], BASE + t_vid[s] * COORD_STRIDE);
               if (exp_ts == t_g[s]) begin
                  g_cases++;
               end
               check_value("child_ts", exp_ts, task_wts);
               check_value("child_vid", t_vid[s], task_wvid);
               check_value("child_parent", t_par[s], task_wparent);
               check_value("child_fscore", t_f[s], task_wfscore);
               fin_q.push_back(s);
            end
            child_count++;
         end
      end
   end

   initial begin
      rstn = 1'b0;
      start = 1'b0;
      coord_base = BASE;
      tgt_lat = TGT_LAT;
      tgt_lon = TGT_LON;
      task_rvalid = '0;
      task_vid = '0;
      task_fscore = '0;
      task_gscore = '0;
      task_parent = '0;
      task_cq_slot = '0;
      mem_arready = 1'b0;
      mem_rvalid = 1'b0;
      mem_rid = '0;
      mem_rlat = '0;
      mem_rlon = '0;
      task_wready = 1'b0;
      finish_ready = '0;
      repeat (4) @(posedge clk);
      #2 rstn = 1'b1;
      // Idle with start low
      repeat (4) begin
         @(posedge clk);
         #2 drive_inputs();
      end
      start = 1'b1;
      while (fin_count < NTASKS && cycles < LIMIT) begin
         @(posedge clk);
         #2 drive_inputs();
      end
      if (fin_count < NTASKS) begin
         timed_out = 1'b1;
         $display("Timeout after %0d cycles with %0d of %0d tasks finished",
            cycles, fin_count, NTASKS);
      end
      assert (deq_count == NTASKS && child_count == NTASKS) else begin
         end_errors++;
         $display("Expected %0d dequeues and children, saw %0d and %0d",
            NTASKS, deq_count, child_count);
      end
      assert (g_cases > 0 && g_cases < child_count) else begin
         end_errors++;
         $display("Children never mixed g-score and distance wins");
      end
      end_errors += i_astar_core.i_astar_core_chk.fails;
      $display("Errors: %0d failed checks, %0d end of run, %0d timeout",
         errors, end_errors, timed_out);
      if (errors == 0 && end_errors == 0 && !timed_out) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: files.f
rtl/astar_pkg.sv
rtl/slot_fifo.sv
rtl/task_dequeue.sv
rtl/dist_pipe.sv
rtl/child_enqueue.sv
rtl/astar_core.sv
test/astar_core_chk.sv
test/astar_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = astar_core_tb
FILELIST = files.f
OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
SRCS = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
